// File: verilog.f
+incdir+.
l2_ctrl_pkg.sv
l2_req_if.sv
l2_req_queue.sv
l2_miss_table.sv
l2_port_arbiter.sv
l2_ctrl_top.sv
l2_ctrl_assert.sv
tb_l2_ctrl.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_l2_ctrl
FILELIST = verilog.f
OBJ = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

// File: tb_l2_ctrl.sv
`timescale 1ns/1ps
`include "l2_ctrl_settings.svh"

module tb_l2_ctrl;

  localparam int max_cycles = 2000;  // far above the length of all tests

  logic clk = 1'b0;
  logic rst;
  logic [2:0] in_valid;  // data, code, miss
  logic [2:0] in_ready;
  l2_ctrl_pkg::l2_req_t in_req [3];
  logic bus_valid;
  logic bus_ready;
  logic [`L2_ADDR_W-1:0] bus_addr;
  logic [`L2_NODE_W+`L2_REQ_W-1:0] bus_src_req;
  logic bus_dupl;
  logic bus_excl;
  logic reply_valid;
  logic [`L2_NODE_W-1:0] reply_node;
  logic [`L2_REQ_W-1:0] reply_req;
  l2_ctrl_pkg::l2_port_op_e port_op;
  logic [`L2_ADDR_W-1:0] port_addr;
  logic [`L2_REQ_W-1:0] port_req;
  logic port_dupl;
  logic port_excl;

  int cycle_cnt = 0;
  logic [15:0] lfsr = 16'd95;
  l2_ctrl_pkg::l2_port_op_e obs_op [$];
  l2_ctrl_pkg::l2_req_t obs_req [$];
  l2_ctrl_pkg::l2_req_t miss_exp [4];

  l2_ctrl_top #(.node_id(5'd3)) dut0 (
    .clk(clk),
    .rst(rst),
    .data_valid(in_valid[0]),
    .data_ready(in_ready[0]),
    .data_addr(in_req[0].addr),
    .data_req(in_req[0].id),
    .data_dupl(in_req[0].dupl),
    .data_excl(in_req[0].excl),
    .code_valid(in_valid[1]),
    .code_ready(in_ready[1]),
    .code_addr(in_req[1].addr),
    .code_req(in_req[1].id),
    .code_dupl(in_req[1].dupl),
    .code_excl(in_req[1].excl),
    .miss_valid(in_valid[2]),
    .miss_ready(in_ready[2]),
    .miss_addr(in_req[2].addr),
    .miss_req(in_req[2].id),
    .miss_dupl(in_req[2].dupl),
    .miss_excl(in_req[2].excl),
    .bus_valid(bus_valid),
    .bus_ready(bus_ready),
    .bus_addr(bus_addr),
    .bus_src_req(bus_src_req),
    .bus_dupl(bus_dupl),
    .bus_excl(bus_excl),
    .reply_valid(reply_valid),
    .reply_node(reply_node),
    .reply_req(reply_req),
    .port_op(port_op),
    .port_addr(port_addr),
    .port_req(port_req),
    .port_dupl(port_dupl),
    .port_excl(port_excl)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
    begin
      $display("timeout: tests still running after %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  // every busy port cycle is one operation
  always @(negedge clk)
  begin
    if (port_op != l2_ctrl_pkg::op_idle)
    begin
      obs_op.push_back(port_op);
      obs_req.push_back({port_addr, port_req, port_dupl, port_excl});
    end
  end

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];
      lfsr = {lfsr[14:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic l2_ctrl_pkg::l2_req_t rand_req(input logic [`L2_REQ_W-1:0] id);
    l2_ctrl_pkg::l2_req_t r;
    r.addr = `L2_ADDR_W'(rand_bits(`L2_ADDR_W));
    r.id = id;
    r.dupl = 1'(rand_bits(1));
    r.excl = 1'(rand_bits(1));
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic compare_obs(input string name, input l2_ctrl_pkg::l2_port_op_e op,
                             input l2_ctrl_pkg::l2_req_t req, input int idx);
    check(name, op, obs_op[idx]);
    check(name, req, obs_req[idx]);
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic push_req(input int s, input l2_ctrl_pkg::l2_req_t r);
    in_req[s] = r;
    in_valid[s] = 1'b1;
    while (!in_ready[s])
      @(negedge clk);
    @(negedge clk);
    in_valid[s] = 1'b0;
  endtask

  task automatic send_reply(input logic [`L2_NODE_W-1:0] node, input logic [`L2_REQ_W-1:0] id);
    reply_valid = 1'b1;
    reply_node = node;
    reply_req = id;
    @(negedge clk);
    reply_valid = 1'b0;
  endtask

  task automatic reset_obs;
    repeat (2) @(negedge clk);
    obs_op.delete();
    obs_req.delete();
  endtask

  task automatic wait_obs(input int n);
    while (obs_op.size() < n)
      @(posedge clk);
    @(negedge clk);
  endtask

  // all queues empty and accepting
  task automatic idle_after_reset;
    check("idle_after_reset", 3'b111, in_ready);
    check("idle_after_reset", 0, bus_valid);
    check("idle_after_reset", l2_ctrl_pkg::op_idle, port_op);
  endtask

  task automatic data_order;
    l2_ctrl_pkg::l2_req_t d [6];
    reset_obs();
    for (int i = 0; i < 6; i++)
    begin
      d[i] = rand_req(`L2_REQ_W'(i));
      push_req(0, d[i]);
    end
    wait_obs(6);
    for (int i = 0; i < 6; i++)
      compare_obs("data_order", l2_ctrl_pkg::op_data_read, d[i], i);
  endtask

  task automatic code_after_data;
    l2_ctrl_pkg::l2_req_t d [5];
    l2_ctrl_pkg::l2_req_t c [4];
    reset_obs();
    for (int i = 0; i < 5; i++)
      d[i] = rand_req(`L2_REQ_W'(8 + i));
    for (int i = 0; i < 4; i++)
      c[i] = rand_req(`L2_REQ_W'(16 + i));
    fork
      for (int i = 0; i < 5; i++)
        push_req(0, d[i]);
      for (int i = 0; i < 4; i++)
        push_req(1, c[i]);
    join
    wait_obs(9);
    for (int i = 0; i < 5; i++)
      compare_obs("code_after_data", l2_ctrl_pkg::op_data_read, d[i], i);
    for (int i = 0; i < 4; i++)
    begin
      c[i].dupl = 1'b0;  // code port drops dupl and excl
      c[i].excl = 1'b0;
      compare_obs("code_after_data", l2_ctrl_pkg::op_code_read, c[i], 5 + i);
    end
  endtask

  task automatic miss_backpressure;
    int seen;
    bus_ready = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      miss_exp[i] = rand_req(`L2_REQ_W'(24 + i));
      push_req(2, miss_exp[i]);
    end
    check("miss_backpressure", miss_exp[0].addr, bus_addr);
    repeat (3)
    begin
      @(negedge clk);
      check("miss_backpressure", 1, bus_valid);
      check("miss_backpressure", miss_exp[0].addr, bus_addr);
    end
    seen = 0;
    while (seen < 4)
    begin
      bus_ready = !bus_ready;
      if (bus_valid && bus_ready)
      begin
        check("miss_backpressure", miss_exp[seen].addr, bus_addr);
        check("miss_backpressure", {5'd3, miss_exp[seen].id}, bus_src_req);
        check("miss_backpressure", {miss_exp[seen].dupl, miss_exp[seen].excl},
              {bus_dupl, bus_excl});
        seen++;
      end
      @(negedge clk);
    end
    bus_ready = 1'b0;
    check("miss_backpressure", 0, bus_valid);  // each miss only once
  endtask

  task automatic reply_insert;
    l2_ctrl_pkg::l2_req_t ins;
    ins = miss_exp[1];
    ins.excl = 1'b0;
    send_reply(5'd3, miss_exp[1].id);
    check("reply_insert", l2_ctrl_pkg::op_insert, port_op);
    check("reply_insert", ins, {port_addr, port_req, port_dupl, port_excl});
    send_reply(5'd5, miss_exp[1].id);  // other node
    check("reply_insert", l2_ctrl_pkg::op_idle, port_op);
    @(negedge clk);
    check("reply_insert", l2_ctrl_pkg::op_idle, port_op);
  endtask

  task automatic insert_over_reads;
    l2_ctrl_pkg::l2_req_t d [3];
    l2_ctrl_pkg::l2_req_t ins;
    reset_obs();
    ins = miss_exp[2];
    ins.excl = 1'b0;
    for (int i = 0; i < 3; i++)
      d[i] = rand_req(`L2_REQ_W'(20 + i));
    fork
      for (int i = 0; i < 3; i++)
        push_req(0, d[i]);
      send_reply(5'd3, miss_exp[2].id);
    join
    wait_obs(4);
    compare_obs("insert_over_reads", l2_ctrl_pkg::op_insert, ins, 0);
    for (int i = 0; i < 3; i++)
      compare_obs("insert_over_reads", l2_ctrl_pkg::op_data_read, d[i], 1 + i);
  endtask

  task automatic miss_queue_full;
    l2_ctrl_pkg::l2_req_t first;
    bus_ready = 1'b0;
    first = rand_req('0);
    push_req(2, first);
    for (int i = 1; i < `L2_MQ_DEPTH; i++)
      push_req(2, rand_req(`L2_REQ_W'(i)));
    check("miss_queue_full", 0, in_ready[2]);
    check("miss_queue_full", first.addr, bus_addr);
    bus_ready = 1'b1;
    @(negedge clk);
    bus_ready = 1'b0;
    check("miss_queue_full", 1, in_ready[2]);
    bus_ready = 1'b1;
    while (bus_valid)
      @(negedge clk);
    bus_ready = 1'b0;
  endtask

  initial
  begin
    rst = 1'b1;
    in_valid = '0;
    for (int i = 0; i < 3; i++)
      in_req[i] = '0;
    bus_ready = 1'b0;
    reply_valid = 1'b0;
    reply_node = '0;
    reply_req = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    idle_after_reset();
    data_order();
    code_after_data();
    miss_backpressure();
    reply_insert();
    insert_over_reads();
    miss_queue_full();
    repeat (4) @(negedge clk);
    $display("Test passed");
    $finish;
  end

endmodule

// File: l2_ctrl_assert.sv
`timescale 1ns/1ps
`include "l2_ctrl_settings.svh"

module l2_ctrl_assert (
  input logic clk,
  input logic rst,
  input logic insert_valid,
  input logic data_head,
  input logic code_head,
  input l2_ctrl_pkg::l2_port_op_e port_op,
  input logic bus_valid,
  input logic bus_ready,
  input logic [`L2_ADDR_W-1:0] bus_addr
);

  l2_ctrl_pkg::l2_grant_e pending;

  always_comb
  begin
    if (insert_valid)
      pending = l2_ctrl_pkg::gnt_reply;
    else if (data_head)
      pending = l2_ctrl_pkg::gnt_data;
    else if (code_head)
      pending = l2_ctrl_pkg::gnt_code;
    else
      pending = l2_ctrl_pkg::gnt_none;
  end

  a_port_busy: assert property (@(posedge clk) disable iff (rst)
    pending != l2_ctrl_pkg::gnt_none |-> port_op != l2_ctrl_pkg::op_idle)
    else $error("cache port idle while a request is waiting");

  // stalled bus request holds its address
  a_bus_hold: assert property (@(posedge clk) disable iff (rst)
    bus_valid && !bus_ready |=> bus_valid && $stable(bus_addr))
    else $error("bus request changed while stalled");

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !bus_valid && port_op == l2_ctrl_pkg::op_idle)
    else $error("bus or cache port active right after reset");

endmodule

bind l2_ctrl_top l2_ctrl_assert u_assert (
  .clk(clk),
  .rst(rst),
  .insert_valid(insert_valid),
  .data_head(data_pop.valid),
  .code_head(code_pop.valid),
  .port_op(port_op),
  .bus_valid(bus_valid),
  .bus_ready(bus_ready),
  .bus_addr(bus_addr)
);

// File: l2_ctrl_top.sv
`timescale 1ns/1ps
`include "l2_ctrl_settings.svh"

module l2_ctrl_top #(
  parameter logic [`L2_NODE_W-1:0] node_id = '0
) (
  input logic clk,
  input logic rst,
  input logic data_valid,
  output logic data_ready,
  input logic [`L2_ADDR_W-1:0] data_addr,
  input logic [`L2_REQ_W-1:0] data_req,
  input logic data_dupl,
  input logic data_excl,
  input logic code_valid,
  output logic code_ready,
  input logic [`L2_ADDR_W-1:0] code_addr,
  input logic [`L2_REQ_W-1:0] code_req,
  input logic code_dupl,
  input logic code_excl,
  input logic miss_valid,
  output logic miss_ready,
  input logic [`L2_ADDR_W-1:0] miss_addr,
  input logic [`L2_REQ_W-1:0] miss_req,
  input logic miss_dupl,
  input logic miss_excl,
  output logic bus_valid,
  input logic bus_ready,
  output logic [`L2_ADDR_W-1:0] bus_addr,
  output logic [`L2_NODE_W+`L2_REQ_W-1:0] bus_src_req,
  output logic bus_dupl,
  output logic bus_excl,
  input logic reply_valid,
  input logic [`L2_NODE_W-1:0] reply_node,
  input logic [`L2_REQ_W-1:0] reply_req,
  output l2_ctrl_pkg::l2_port_op_e port_op,
  output logic [`L2_ADDR_W-1:0] port_addr,
  output logic [`L2_REQ_W-1:0] port_req,
  output logic port_dupl,
  output logic port_excl
);

  l2_req_if data_push ();
  l2_req_if data_pop ();
  l2_req_if code_push ();
  l2_req_if code_pop ();
  l2_req_if miss_push ();
  l2_req_if miss_pop ();

  logic insert_valid;
  l2_ctrl_pkg::l2_req_t insert_req;
  l2_ctrl_pkg::l2_req_t port_req_w;

  assign data_push.valid = data_valid;
  assign data_push.req = '{addr: data_addr, id: data_req, dupl: data_dupl, excl: data_excl};
  assign data_ready = data_push.ready;

  assign code_push.valid = code_valid;
  assign code_push.req = '{addr: code_addr, id: code_req, dupl: code_dupl, excl: code_excl};
  assign code_ready = code_push.ready;

  assign miss_push.valid = miss_valid;
  assign miss_push.req = '{addr: miss_addr, id: miss_req, dupl: miss_dupl, excl: miss_excl};
  assign miss_ready = miss_push.ready;

  // miss queue head goes straight out on the bus
  assign bus_valid = miss_pop.valid;
  assign miss_pop.ready = bus_ready;
  assign bus_addr = miss_pop.req.addr;
  assign bus_src_req = {node_id, miss_pop.req.id};
  assign bus_dupl = miss_pop.req.dupl;
  assign bus_excl = miss_pop.req.excl;

  assign port_addr = port_req_w.addr;
  assign port_req = port_req_w.id;
  assign port_dupl = port_req_w.dupl;
  assign port_excl = port_req_w.excl;

  l2_req_queue #(.depth(`L2_DQ_DEPTH)) u_data_q (
    .clk(clk),
    .rst(rst),
    .push(data_push.snk),
    .pop(data_pop.src)
  );

  l2_req_queue #(.depth(`L2_CQ_DEPTH)) u_code_q (
    .clk(clk),
    .rst(rst),
    .push(code_push.snk),
    .pop(code_pop.src)
  );

  l2_req_queue #(.depth(`L2_MQ_DEPTH)) u_miss_q (
    .clk(clk),
    .rst(rst),
    .push(miss_push.snk),
    .pop(miss_pop.src)
  );

  l2_miss_table #(.node_id(node_id)) u_miss_table (
    .clk(clk),
    .rst(rst),
    .miss_wen(miss_valid && miss_ready),  // table written on every accepted miss
    .miss_req(miss_push.req),
    .reply_valid(reply_valid),
    .reply_node(reply_node),
    .reply_req(reply_req),
    .insert_valid(insert_valid),
    .insert_req(insert_req)
  );

  l2_port_arbiter u_arb (
    .insert_valid(insert_valid),
    .insert_req(insert_req),
    .data(data_pop.snk),
    .code(code_pop.snk),
    .port_op(port_op),
    .port_req(port_req_w)
  );

endmodule

// File: l2_port_arbiter.sv
`timescale 1ns/1ps

module l2_port_arbiter (
  input logic insert_valid,
  input l2_ctrl_pkg::l2_req_t insert_req,
  l2_req_if.snk data,
  l2_req_if.snk code,
  output l2_ctrl_pkg::l2_port_op_e port_op,
  output l2_ctrl_pkg::l2_req_t port_req
);

  l2_ctrl_pkg::l2_grant_e grant;

  // fixed priority, reply insert first
  always_comb
  begin
    if (insert_valid)
      grant = l2_ctrl_pkg::gnt_reply;
    else if (data.valid)
      grant = l2_ctrl_pkg::gnt_data;
    else if (code.valid)
      grant = l2_ctrl_pkg::gnt_code;
    else
      grant = l2_ctrl_pkg::gnt_none;
  end

  // pop only the winning queue
  assign data.ready = grant == l2_ctrl_pkg::gnt_data;
  assign code.ready = grant == l2_ctrl_pkg::gnt_code;

  always_comb
  begin
    port_op = l2_ctrl_pkg::op_idle;
    port_req = '0;
    case (grant)
      l2_ctrl_pkg::gnt_reply:
      begin
        port_op = l2_ctrl_pkg::op_insert;
        port_req = insert_req;
      end
      l2_ctrl_pkg::gnt_data:
      begin
        port_op = l2_ctrl_pkg::op_data_read;
        port_req = data.req;
      end
      l2_ctrl_pkg::gnt_code:
      begin
        port_op = l2_ctrl_pkg::op_code_read;
        port_req.addr = code.req.addr;
        port_req.id = code.req.id;  // code fetch carries no dupl or excl
      end
      default:
      begin
        port_op = l2_ctrl_pkg::op_idle;
      end
    endcase
  end

endmodule

// File: l2_miss_table.sv
`timescale 1ns/1ps
`include "l2_ctrl_settings.svh"

module l2_miss_table #(
  parameter logic [`L2_NODE_W-1:0] node_id = '0
) (
  input logic clk,
  input logic rst,
  input logic miss_wen,
  input l2_ctrl_pkg::l2_req_t miss_req,
  input logic reply_valid,
  input logic [`L2_NODE_W-1:0] reply_node,
  input logic [`L2_REQ_W-1:0] reply_req,
  output logic insert_valid,
  output l2_ctrl_pkg::l2_req_t insert_req
);

  localparam int entries = 2 ** `L2_REQ_W;

  logic [`L2_ADDR_W-1:0] addr_mem [entries];
  logic dupl_mem [entries];
  logic reply_hit_q;
  logic [`L2_REQ_W-1:0] reply_id_q;

  // miss remembered under its own request id
  always_ff @(posedge clk)
  begin
    if (miss_wen)
    begin
      addr_mem[miss_req.id] <= miss_req.addr;
      dupl_mem[miss_req.id] <= miss_req.dupl;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      reply_hit_q <= 1'b0;
    else
      reply_hit_q <= reply_valid && (reply_node == node_id);  // other nodes dropped
  end

  always_ff @(posedge clk)
  begin
    reply_id_q <= reply_req;
  end

  assign insert_valid = reply_hit_q;

  // table read at the registered id, insert never wants exclusive
  assign insert_req = '{
    addr: addr_mem[reply_id_q],
    id: reply_id_q,
    dupl: dupl_mem[reply_id_q],
    excl: 1'b0
  };

endmodule

// File: l2_req_queue.sv
`timescale 1ns/1ps

module l2_req_queue #(
  parameter int depth = 16
) (
  input logic clk,
  input logic rst,
  l2_req_if.snk push,
  l2_req_if.src pop
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

  l2_ctrl_pkg::l2_req_t mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic push_fire;
  logic pop_fire;

  assign push.ready = count < cnt_w'(depth);
  assign pop.valid = count != '0;
  assign pop.req = mem[rd_ptr];  // head read at the registered pointer

  assign push_fire = push.valid && push.ready;
  assign pop_fire = pop.valid && pop.ready;

  always_ff @(posedge clk)
  begin
    if (push_fire)
      mem[wr_ptr] <= push.req;
  end

  // pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push_fire)
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      if (pop_fire)
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      if (push_fire && !pop_fire)
        count <= count + 1'b1;
      else if (pop_fire && !push_fire)
        count <= count - 1'b1;  // push with pop keeps count
    end
  end

endmodule

// File: l2_req_if.sv
`timescale 1ns/1ps

// one request stream, transfer on valid && ready
interface l2_req_if;

  logic valid;
  logic ready;
  l2_ctrl_pkg::l2_req_t req;

  modport src (
    output valid,
    output req,
    input ready
  );

  modport snk (
    input valid,
    input req,
    output ready
  );

endinterface

// File: l2_ctrl_pkg.sv
`include "l2_ctrl_settings.svh"

package l2_ctrl_pkg;

  // one buffered request, 44 bits
  typedef struct packed {
    logic [`L2_ADDR_W-1:0] addr;
    logic [`L2_REQ_W-1:0] id;
    logic dupl;
    logic excl;  // want exclusive
  } l2_req_t;

  // what the cache port does this cycle
  typedef enum logic [1:0] {
    op_idle,
    op_insert,
    op_data_read,
    op_code_read
  } l2_port_op_e;

  typedef enum logic [1:0] {
    gnt_none,
    gnt_reply,
    gnt_data,
    gnt_code
  } l2_grant_e;

endpackage

// File: l2_ctrl_settings.svh
`ifndef L2_CTRL_SETTINGS_SVH
`define L2_CTRL_SETTINGS_SVH

// physical line address
`define L2_ADDR_W 37

// request id, miss table holds 2**L2_REQ_W entries
`define L2_REQ_W 5

`define L2_NODE_W 5

// queue depths
`define L2_DQ_DEPTH 16
`define L2_CQ_DEPTH 8
`define L2_MQ_DEPTH 24

`endif
